// ==== dv/clockGen.sv ====
module clockGen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end
endmodule

// ==== dv/idStageTb.sv ====
module idStageTb import mipsPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] handlerVector = 32'h0000_0180;

    typedef struct {
        logic [31:0] opA, opB, imm, nextPc, rtVal;
        logic [4:0]  wAddr;
        aluOpE       aluOp;
        logic        regWrite, memWrite, memToReg, stall, takeJump, flush, trap, eret, mtc0;
        logic        aluSrcImm, shiftUseShamt;
    } expT;

    logic clk, rst;
    logic [31:0] pc4, instruction, wbWriteData, exAluOut, memAluOut, memData;
    logic [2:0]  irq;
    logic        wbRegWrite, exRegWrite, exMemToReg, memRegWrite, memMemToReg;
    logic [4:0]  wbWriteAddr, exWriteAddr, memWriteAddr;
    logic [31:0] nextPc, operandA, operandB, immediate;
    logic        takeJump, flush, stall, regWrite, memWrite, memToReg, aluSrcImm, shiftUseShamt;
    logic [4:0]  writeAddr;
    aluOpE       aluOp;

    // shadow state of the register file and CP0
    logic [31:0] shadow [0:31];
    logic [31:0] mEpc, mCount, mCompare;
    logic [2:0]  mCause;
    logic        mIntEn, mExl, mTimer;
    logic [1:0]  mState;
    logic [15:0] lfsr = 16'd61789;
    int          n;
    logic [31:0] timerStart;

    clockGen clkGen0 (.clk(clk), .rst(rst));

    idStage #(.handlerVector(handlerVector), .timerWidth(32)) dut0 (.*);

    // taps 16,14,13,11
    function automatic logic [31:0] randBits(input int width);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < width; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] regValue(input logic [4:0] src);
        if (src == 5'd0) return '0;
        if (wbRegWrite && wbWriteAddr == src) return wbWriteData;
        return shadow[src];
    endfunction

    function automatic logic [31:0] fwdValue(input logic [4:0] src);
        if (src == 5'd0) return '0;
        if (exRegWrite && exWriteAddr == src) return exAluOut;
        if (memRegWrite && memWriteAddr == src) return memMemToReg ? memData : memAluOut;
        return regValue(src);
    endfunction

    function automatic logic [31:0] cp0Read(input logic [4:0] addr);
        case (addr)
            5'd9:    return mCount;
            5'd11:   return mCompare;
            5'd12:   return {30'b0, mExl, mIntEn};
            5'd13:   return {21'b0, mCause, 8'b0};
            5'd14:   return mEpc;
            default: return '0;
        endcase
    endfunction

    function automatic expT refModel();
        expT         e;
        logic [5:0]  op;
        logic [4:0]  rs, rt, rd;
        logic [31:0] a, b;
        logic        w, readsRt, isMfc0, isEret, isJr, taken;
        op = instruction[31:26];
        rs = instruction[25:21];
        rt = instruction[20:16];
        rd = instruction[15:11];
        a = fwdValue(rs);
        b = fwdValue(rt);
        e.aluOp = aluAdd;
        e.memWrite = 1'b0;
        e.memToReg = 1'b0;
        e.aluSrcImm = 1'b1;
        w = 1'b0;
        readsRt = 1'b0;
        isJr = op == 6'h00 && instruction[5:0] == 6'h08;
        case (op)
            6'h00: begin
                readsRt = 1'b1;
                e.aluSrcImm = 1'b0;
                w = !isJr;
                case (instruction[5:0])
                    6'h22: e.aluOp = aluSub;
                    6'h24: e.aluOp = aluAnd;
                    6'h25: e.aluOp = aluOr;
                    6'h2a: e.aluOp = aluSlt;
                    6'h00: e.aluOp = aluSll;
                    6'h02: e.aluOp = aluSrl;
                    default: e.aluOp = aluAdd;
                endcase
            end
            6'h03, 6'h08: begin
                w = 1'b1;
                e.aluSrcImm = op != 6'h03;
            end
            6'h04, 6'h05, 6'h2b: begin
                readsRt = 1'b1;
                e.memWrite = op == 6'h2b;
            end
            6'h0a: begin
                e.aluOp = aluSlt;
                w = 1'b1;
            end
            6'h0c: begin
                e.aluOp = aluAnd;
                w = 1'b1;
            end
            6'h0d: begin
                e.aluOp = aluOr;
                w = 1'b1;
            end
            6'h0f: begin
                e.aluOp = aluLui;
                w = 1'b1;
            end
            6'h23: begin
                w = 1'b1;
                e.memToReg = 1'b1;
            end
            6'h10: begin
                w = rs == 5'd0;
                readsRt = rs == 5'd4;
                e.aluSrcImm = 1'b0;
            end
            default: ;
        endcase
        e.shiftUseShamt = op == 6'h00 &&
                          (instruction[5:0] == 6'h00 || instruction[5:0] == 6'h02);
        isMfc0 = op == 6'h10 && rs == 5'd0;
        isEret = op == 6'h10 && rs[4] && instruction[5:0] == 6'h18;
        e.imm = (op == 6'h0c || op == 6'h0d) ? {16'h0, instruction[15:0]} :
                {{16{instruction[15]}}, instruction[15:0]};
        e.wAddr = op == 6'h03 ? 5'd31 : op == 6'h00 ? rd : rt;
        e.stall = exMemToReg && exRegWrite && exWriteAddr != 5'd0 &&
                  (exWriteAddr == rs || (readsRt && exWriteAddr == rt));
        e.trap = mState == 2'd0 && (irq != 3'b0 || mTimer) && mIntEn && !mExl && !e.stall;
        e.eret = mState == 2'd2 && isEret && mExl && !e.stall;
        e.regWrite = w && !e.stall && !e.trap;
        e.memWrite = e.memWrite && !e.stall && !e.trap;
        e.mtc0 = op == 6'h10 && rs == 5'd4 && !e.stall && !e.trap;
        e.opA = op == 6'h03 ? pc4 : a;
        e.opB = op == 6'h03 ? '0 : isMfc0 ? cp0Read(rd) : b;
        e.rtVal = b;
        taken = op == 6'h02 || op == 6'h03 || isJr || (op == 6'h04 && a == b) ||
                (op == 6'h05 && a != b);
        e.takeJump = e.trap || e.eret || (taken && !e.stall);
        e.flush = e.trap || e.eret;
        e.nextPc = e.trap ? handlerVector : e.eret ? mEpc : isJr ? a :
                   (op == 6'h02 || op == 6'h03) ? {pc4[31:28], instruction[25:0], 2'b00} :
                   pc4 + {{14{instruction[15]}}, instruction[15:0], 2'b00};
        return e;
    endfunction

    task automatic failNow();
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            failNow();
        end
    endtask

    task automatic checkAddr(input string name, input logic [4:0] got, input logic [4:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            failNow();
        end
    endtask

    task automatic checkAluOp(input string name, input aluOpE got, input aluOpE exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            failNow();
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            failNow();
        end
    endtask

    // the model steps forward with the clock edge that follows the check
    task automatic advanceModel(input expT e);
        logic [4:0] rd;
        rd = instruction[15:11];
        if (wbRegWrite && wbWriteAddr != 5'd0) shadow[wbWriteAddr] = wbWriteData;
        if (e.trap) begin
            mEpc = pc4 - 32'd4;
            mCause = {irq[2] | mTimer, irq[1:0]};
            mExl = 1'b1;
        end else if (e.mtc0 && rd == 5'd14) begin
            mEpc = e.rtVal;
        end
        if (e.mtc0 && rd == 5'd12) mIntEn = e.rtVal[0];
        if (e.mtc0 && rd == 5'd11) begin
            mCompare = e.rtVal;
            mTimer = 1'b0;
        end else if (mCount == mCompare && mCompare != '0) begin
            mTimer = 1'b1;
        end
        mCount = mCount + 32'd1;
        if (e.eret) mExl = 1'b0;
        case (mState)
            2'd0: if (e.trap) mState = 2'd1;
            2'd1: mState = 2'd2;
            2'd2: if (e.eret) mState = 2'd3;
            default: mState = 2'd0;
        endcase
    endtask

    always @(negedge clk) begin
        expT e;
        if (rst) begin
            for (int i = 0; i < 32; i++) shadow[i] = '0;
            {mEpc, mCount, mCompare, mCause, mIntEn, mExl, mTimer, mState} = '0;
        end else begin
            e = refModel();
            checkBit("stall", stall, e.stall);
            checkBit("regWrite", regWrite, e.regWrite);
            checkBit("memWrite", memWrite, e.memWrite);
            checkBit("memToReg", memToReg, e.memToReg);
            checkBit("aluSrcImm", aluSrcImm, e.aluSrcImm);
            checkBit("shiftUseShamt", shiftUseShamt, e.shiftUseShamt);
            checkBit("takeJump", takeJump, e.takeJump);
            checkBit("flush", flush, e.flush);
            if (e.takeJump) checkWord("nextPc", nextPc, e.nextPc);
            checkWord("operandA", operandA, e.opA);
            checkWord("operandB", operandB, e.opB);
            checkWord("immediate", immediate, e.imm);
            checkAddr("writeAddr", writeAddr, e.wAddr);
            checkAluOp("aluOp", aluOp, e.aluOp);
            advanceModel(e);
        end
    end

    function automatic logic [31:0] randInstr();
        logic [4:0]  rs, rt, rd;
        logic [15:0] imm;
        rs = randBits(3);
        rt = randBits(3);
        rd = randBits(3);
        imm = randBits(16);
        case (randBits(5) % 19)
            0: return {6'h00, rs, rt, rd, imm[4:0], 6'h20};
            1: return {6'h00, rs, rt, rd, imm[4:0], 6'h22};
            2: return {6'h00, rs, rt, rd, imm[4:0], 6'h24};
            3: return {6'h00, rs, rt, rd, imm[4:0], 6'h25};
            4: return {6'h00, rs, rt, rd, imm[4:0], 6'h2a};
            5: return {6'h00, rs, rt, rd, imm[4:0], 6'h00};
            6: return {6'h00, rs, rt, rd, imm[4:0], 6'h02};
            7: return {6'h00, rs, 15'b0, 6'h08};
            8: return {6'h02, 26'(randBits(26))};
            9: return {6'h03, 26'(randBits(26))};
            10: return {6'h04, rs, rt, imm};
            11: return {6'h05, rs, rt, imm};
            12: return {6'h08, rs, rt, imm};
            13: return {6'h0a, rs, rt, imm};
            14: return {6'h0c, rs, rt, imm};
            15: return {6'h0d, rs, rt, imm};
            16: return {6'h0f, rs, rt, imm};
            17: return {6'h23, rs, rt, imm};
            default: return {6'h2b, rs, rt, imm};
        endcase
    endfunction

    task automatic waitFlush(output int cycles);
        cycles = 0;
        @(negedge clk);
        while (!flush) begin
            cycles++;
            if (cycles > 20) begin
                $display("timed out waiting for a flush from the exception sequencer");
                failNow();
            end
            @(negedge clk);
        end
    endtask

    initial begin
        {pc4, instruction, wbWriteData, exAluOut, memAluOut, memData} <= '0;
        {irq, wbRegWrite, exRegWrite, exMemToReg, memRegWrite, memMemToReg} <= '0;
        {wbWriteAddr, exWriteAddr, memWriteAddr} <= '0;
        n = 0;
        @(posedge clk);
        while (rst) begin
            n++;
            if (n > 10) begin
                $display("reset never released");
                failNow();
            end
            @(posedge clk);
        end
        // fill registers, reading the same one as is written
        repeat (40) begin
            @(posedge clk);
            pc4 <= randBits(32);
            instruction <= {6'h00, 5'(randBits(3)), 5'(randBits(3)), 5'(randBits(5)), 11'h020};
            wbRegWrite <= 1'b1;
            wbWriteAddr <= randBits(3);
            wbWriteData <= randBits(32);
        end
        repeat (400) begin
            @(posedge clk);
            pc4 <= randBits(32);
            instruction <= randInstr();
            wbRegWrite <= randBits(1);
            wbWriteAddr <= randBits(3);
            wbWriteData <= randBits(32);
            exRegWrite <= randBits(1);
            exMemToReg <= randBits(1);
            exWriteAddr <= randBits(3);
            exAluOut <= randBits(32);
            memRegWrite <= randBits(1);
            memMemToReg <= randBits(1);
            memWriteAddr <= randBits(3);
            memAluOut <= randBits(32);
            memData <= randBits(32);
        end
        // interrupts: enable through status, then raise irq
        @(posedge clk);
        {exRegWrite, memRegWrite} <= '0;
        instruction <= {6'h10, 5'd4, 5'd1, 5'd12, 11'b0};
        wbRegWrite <= 1'b1;
        wbWriteAddr <= 5'd1;
        wbWriteData <= 32'd1;
        @(posedge clk);
        wbRegWrite <= 1'b0;
        instruction <= '0;
        @(posedge clk);
        pc4 <= 32'h0000_4000;
        irq <= 3'b010;
        waitFlush(n);
        if (n != 0) begin
            $display("interrupt trap was not taken in the cycle irq was raised");
            failNow();
        end
        checkWord("nextPc", nextPc, handlerVector);
        @(posedge clk);
        irq <= 3'b000;
        pc4 <= 32'h0000_5000;
        instruction <= {6'h10, 5'd0, 5'd2, 5'd14, 11'b0};
        @(negedge clk);
        checkWord("epc", operandB, 32'h0000_3ffc);
        @(posedge clk);
        instruction <= {6'h10, 5'b10000, 15'b0, 6'h18};
        waitFlush(n);
        if (n != 0) begin
            $display("eret did not redirect in its own cycle");
            failNow();
        end
        checkWord("nextPc", nextPc, 32'h0000_3ffc);
        @(posedge clk);
        instruction <= '0;
        // compare six counts ahead, flag one edge after the match
        @(posedge clk);
        timerStart = mCount;
        instruction <= {6'h10, 5'd4, 5'd3, 5'd11, 11'b0};
        wbRegWrite <= 1'b1;
        wbWriteAddr <= 5'd3;
        wbWriteData <= timerStart + 32'd6;
        @(posedge clk);
        wbRegWrite <= 1'b0;
        instruction <= '0;
        waitFlush(n);
        if (n != 6) begin
            $display("timer interrupt was not taken on the cycle after the compare match");
            failNow();
        end
        checkWord("nextPc", nextPc, handlerVector);
        @(negedge clk);
        $display("STATUS: PASS");
        $finish;
    end
endmodule

// ==== idStage.f ====
src/mipsPkg.sv
src/idInterfaces.sv
src/regFile.sv
src/controlDecoder.sv
src/operandSelect.sv
src/exceptionFsm.sv
src/cp0Timer.sv
src/cp0Regs.sv
src/idStage.sv
dv/clockGen.sv
dv/idStageTb.sv

// ==== src/controlDecoder.sv ====
module controlDecoder import mipsPkg::*; (
    input  logic [31:0] instruction,
    input  logic        exRegWrite,
    input  logic        exMemToReg,
    input  logic [4:0]  exWriteAddr,
    input  logic        memRegWrite,
    input  logic        memMemToReg,
    input  logic [4:0]  memWriteAddr,
    input  logic        trapTaken,
    idCtrlIf.decoder    ctrl,
    output cp0OpE       cp0Op,
    output logic [4:0]  writeAddr,
    output aluOpE       aluOp,
    output logic        regWrite,
    output logic        memWrite,
    output logic        memToReg,
    output logic        aluSrcImm,
    output logic        shiftUseShamt,
    output logic        stall
);
    opcodeE     opcode;
    functE      funct;
    logic [4:0] rs;
    logic [4:0] rt;
    logic       readsRt;
    logic       writeRaw;
    logic       memWriteRaw;
    cp0OpE      cp0Raw;

    assign opcode = opcodeE'(instruction[31:26]);
    assign funct  = functE'(instruction[5:0]);
    assign rs     = instruction[25:21];
    assign rt     = instruction[20:16];

    function automatic fwdSelE fwdFor(input logic [4:0] src);
        if (src == 5'd0) return fwdReg;
        if (exRegWrite && exWriteAddr == src) return fwdExAlu;
        if (memRegWrite && memWriteAddr == src) return memMemToReg ? fwdMemData : fwdMemAlu;
        return fwdReg;
    endfunction

    always_comb begin
        ctrl.jump = 1'b0;
        ctrl.jumpReg = 1'b0;
        ctrl.jal = 1'b0;
        ctrl.branchEq = 1'b0;
        ctrl.branchNe = 1'b0;
        ctrl.signExt = 1'b1;
        ctrl.mfc0Sel = 1'b0;
        aluOp = aluAdd;
        writeRaw = 1'b0;
        memWriteRaw = 1'b0;
        memToReg = 1'b0;
        aluSrcImm = 1'b1;
        shiftUseShamt = 1'b0;
        cp0Raw = cpNone;
        readsRt = 1'b0;
        case (opcode)
            opRtype: begin
                aluSrcImm = 1'b0;
                readsRt = 1'b1;
                writeRaw = 1'b1;
                case (funct)
                    fnAdd: aluOp = aluAdd;
                    fnSub: aluOp = aluSub;
                    fnAnd: aluOp = aluAnd;
                    fnOr:  aluOp = aluOr;
                    fnSlt: aluOp = aluSlt;
                    fnSll: begin
                        aluOp = aluSll;
                        shiftUseShamt = 1'b1;
                    end
                    fnSrl: begin
                        aluOp = aluSrl;
                        shiftUseShamt = 1'b1;
                    end
                    fnJr: begin
                        ctrl.jumpReg = 1'b1;
                        writeRaw = 1'b0;
                    end
                    default: writeRaw = 1'b0;
                endcase
            end
            opJ: ctrl.jump = 1'b1;
            opJal: begin
                ctrl.jump = 1'b1;
                ctrl.jal = 1'b1;
                writeRaw = 1'b1;
                aluSrcImm = 1'b0;
            end
            opBeq: begin
                ctrl.branchEq = 1'b1;
                readsRt = 1'b1;
            end
            opBne: begin
                ctrl.branchNe = 1'b1;
                readsRt = 1'b1;
            end
            opAddi: writeRaw = 1'b1;
            opSlti: begin
                aluOp = aluSlt;
                writeRaw = 1'b1;
            end
            opAndi: begin
                aluOp = aluAnd;
                ctrl.signExt = 1'b0;
                writeRaw = 1'b1;
            end
            opOri: begin
                aluOp = aluOr;
                ctrl.signExt = 1'b0;
                writeRaw = 1'b1;
            end
            opLui: begin
                aluOp = aluLui;
                writeRaw = 1'b1;
            end
            opLw: begin
                writeRaw = 1'b1;
                memToReg = 1'b1;
            end
            opSw: begin
                memWriteRaw = 1'b1;
                readsRt = 1'b1;
            end
            opCop0: begin
                aluSrcImm = 1'b0;
                if (rs == 5'b00000) begin
                    // rs field is zero, so A reads 0 and EX passes B through
                    cp0Raw = cpMfc0;
                    ctrl.mfc0Sel = 1'b1;
                    writeRaw = 1'b1;
                end else if (rs == 5'b00100) begin
                    cp0Raw = cpMtc0;
                    readsRt = 1'b1;
                end else if (rs[4] && instruction[5:0] == 6'h18) begin
                    cp0Raw = cpEret;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        ctrl.rsSel = fwdFor(rs);
        ctrl.rtSel = fwdFor(rt);
    end

    // load in EX feeding this instruction
    assign stall = exMemToReg && exRegWrite && exWriteAddr != 5'd0 &&
                   (exWriteAddr == rs || (readsRt && exWriteAddr == rt));

    assign regWrite  = writeRaw && !stall && !trapTaken;
    assign memWrite  = memWriteRaw && !stall && !trapTaken;
    assign cp0Op     = (stall || trapTaken) ? cpNone : cp0Raw;
    assign writeAddr = ctrl.jal ? 5'd31 : (opcode == opRtype) ? instruction[15:11] : rt;
endmodule

// ==== src/cp0Regs.sv ====
module cp0Regs import mipsPkg::*; #(
    parameter int timerWidth = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    cp0CtrlIf.regs                cp0,
    input  cp0OpE                 cp0Op,
    input  logic [4:0]            regAddr,
    input  logic [31:0]           writeData,
    input  logic [timerWidth-1:0] count,
    input  logic [timerWidth-1:0] compare,
    output logic [31:0]           readData,
    output logic                  compareWrite
);
    cp0RegE      target;
    logic        mtc0;
    logic        intEnable;
    logic        exl;
    logic [2:0]  causeIp;
    logic [31:0] epc;

    assign target       = cp0RegE'(regAddr);
    assign mtc0         = cp0Op == cpMtc0;
    assign compareWrite = mtc0 && target == cpCompare;

    always_ff @(posedge clk) begin
        if (rst) begin
            intEnable <= 1'b0;
            exl       <= 1'b0;
            causeIp   <= '0;
            epc       <= '0;
        end else begin
            if (cp0.setExl) exl <= 1'b1;
            else if (cp0.clearExl) exl <= 1'b0;
            if (cp0.saveEpc) begin
                epc     <= writeData;
                causeIp <= cp0.causeCode;
            end else if (mtc0 && target == cpEpc) begin
                epc <= writeData;
            end
            if (mtc0 && target == cpStatus) intEnable <= writeData[0];
        end
    end

    always_comb begin
        case (target)
            cpCount:   readData = 32'(count);
            cpCompare: readData = 32'(compare);
            cpStatus:  readData = {30'b0, exl, intEnable};
            cpCause:   readData = {21'b0, causeIp, 8'b0};
            cpEpc:     readData = epc;
            default:   readData = '0;
        endcase
    end

    assign cp0.exl       = exl;
    assign cp0.intEnable = intEnable;
    assign cp0.epc       = epc;

    exlSetClearExclusive: assert property (@(posedge clk) disable iff (rst)
        !(cp0.setExl && cp0.clearExl));
endmodule

// ==== src/cp0Timer.sv ====
module cp0Timer #(
    parameter int timerWidth = 32
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  compareWrite,
    input  logic [timerWidth-1:0] compareValue,
    output logic [timerWidth-1:0] count,
    output logic [timerWidth-1:0] compare,
    output logic                  timerIrq
);
    always_ff @(posedge clk) begin
        if (rst) begin
            count    <= '0;
            compare  <= '0;
            timerIrq <= 1'b0;
        end else begin
            count <= count + 1'b1;
            if (compareWrite) begin
                compare  <= compareValue;
                timerIrq <= 1'b0;
            end else if (count == compare && compare != '0) begin
                // zero compare keeps the timer quiet
                timerIrq <= 1'b1;
            end
        end
    end
endmodule

// ==== src/exceptionFsm.sv ====
module exceptionFsm import mipsPkg::*; #(
    parameter logic [31:0] handlerVector = 32'h0000_0180
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [2:0]  irq,
    input  logic        timerIrq,
    input  cp0OpE       cp0Op,
    input  logic        stall,
    input  logic [31:0] pc4,
    cp0CtrlIf.fsm       cp0,
    output logic        trapTaken,
    output logic        redirectValid,
    output logic [31:0] redirectPc,
    output logic        flush
);
    excStateE state;
    logic     pending;
    logic     eretTaken;

    assign pending   = (irq != 3'b000) || timerIrq;
    assign trapTaken = state == excIdle && pending && cp0.intEnable && !cp0.exl && !stall;
    assign eretTaken = state == excHandler && cp0Op == cpEret && cp0.exl;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= excIdle;
        end else begin
            case (state)
                excIdle:    if (trapTaken) state <= excTrap;
                excTrap:    state <= excHandler;
                excHandler: if (eretTaken) state <= excReturn;
                default:    state <= excIdle;
            endcase
        end
    end

    assign cp0.saveEpc   = trapTaken;
    assign cp0.setExl    = trapTaken;
    assign cp0.clearExl  = eretTaken;
    // timer shares line 2 with the external irq
    assign cp0.causeCode = {irq[2] | timerIrq, irq[1:0]};

    assign redirectValid = trapTaken || eretTaken;
    assign redirectPc    = trapTaken ? handlerVector : cp0.epc;
    assign flush         = redirectValid;

    // trapped instruction is re-fetched from pc4 - 4
    epcMatchesTrap: assert property (@(posedge clk) disable iff (rst)
        trapTaken |=> cp0.epc == $past(pc4) - 32'd4);
endmodule

// ==== src/idInterfaces.sv ====
interface idCtrlIf import mipsPkg::*; ();
    fwdSelE rsSel;
    fwdSelE rtSel;
    logic   jump;
    logic   jumpReg;
    logic   jal;
    logic   branchEq;
    logic   branchNe;
    logic   signExt;
    logic   mfc0Sel;

    modport decoder (output rsSel, rtSel, jump, jumpReg, jal, branchEq, branchNe, signExt,
                     mfc0Sel);
    modport operand (input rsSel, rtSel, jump, jumpReg, jal, branchEq, branchNe, signExt,
                     mfc0Sel);
endinterface

interface cp0CtrlIf ();
    logic        saveEpc;
    logic        setExl;
    logic        clearExl;
    logic [2:0]  causeCode;
    logic        exl;
    logic        intEnable;
    logic [31:0] epc;

    modport fsm (output saveEpc, setExl, clearExl, causeCode, input exl, intEnable, epc);
    modport regs (input saveEpc, setExl, clearExl, causeCode, output exl, intEnable, epc);
endinterface

// ==== src/idStage.sv ====
module idStage import mipsPkg::*; #(
    parameter logic [31:0] handlerVector = 32'h0000_0180,
    parameter int          timerWidth    = 32
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] pc4,
    input  logic [31:0] instruction,
    input  logic [2:0]  irq,
    input  logic        wbRegWrite,
    input  logic [4:0]  wbWriteAddr,
    input  logic [31:0] wbWriteData,
    input  logic        exRegWrite,
    input  logic        exMemToReg,
    input  logic [4:0]  exWriteAddr,
    input  logic [31:0] exAluOut,
    input  logic        memRegWrite,
    input  logic        memMemToReg,
    input  logic [4:0]  memWriteAddr,
    input  logic [31:0] memAluOut,
    input  logic [31:0] memData,
    output logic [31:0] nextPc,
    output logic        takeJump,
    output logic        flush,
    output logic        stall,
    output logic [31:0] operandA,
    output logic [31:0] operandB,
    output logic [31:0] immediate,
    output logic [4:0]  writeAddr,
    output aluOpE       aluOp,
    output logic        regWrite,
    output logic        memWrite,
    output logic        memToReg,
    output logic        aluSrcImm,
    output logic        shiftUseShamt
);
    logic [31:0]           regA;
    logic [31:0]           regB;
    logic [31:0]           rtValue;
    logic [31:0]           cp0ReadData;
    logic [31:0]           redirectPc;
    logic                  redirectValid;
    logic                  trapTaken;
    logic                  timerIrq;
    logic                  compareWrite;
    logic [timerWidth-1:0] count;
    logic [timerWidth-1:0] compare;
    cp0OpE                 cp0Op;

    idCtrlIf  ctrlBus ();
    cp0CtrlIf cp0Bus ();

    regFile regs0 (
        .clk(clk), .rst(rst), .writeEnable(wbRegWrite), .writeAddr(wbWriteAddr),
        .writeData(wbWriteData), .readAddrA(instruction[25:21]),
        .readAddrB(instruction[20:16]), .readDataA(regA), .readDataB(regB)
    );

    controlDecoder decode0 (
        .instruction(instruction), .exRegWrite(exRegWrite), .exMemToReg(exMemToReg),
        .exWriteAddr(exWriteAddr), .memRegWrite(memRegWrite), .memMemToReg(memMemToReg),
        .memWriteAddr(memWriteAddr), .trapTaken(trapTaken), .ctrl(ctrlBus.decoder),
        .cp0Op(cp0Op), .writeAddr(writeAddr), .aluOp(aluOp), .regWrite(regWrite),
        .memWrite(memWrite), .memToReg(memToReg), .aluSrcImm(aluSrcImm),
        .shiftUseShamt(shiftUseShamt), .stall(stall)
    );

    operandSelect operands0 (
        .ctrl(ctrlBus.operand), .instruction(instruction), .pc4(pc4), .regA(regA),
        .regB(regB), .exAluOut(exAluOut), .memAluOut(memAluOut), .memData(memData),
        .cp0Data(cp0ReadData), .stall(stall), .redirectValid(redirectValid),
        .redirectPc(redirectPc), .operandA(operandA), .operandB(operandB),
        .rtValue(rtValue), .immediate(immediate), .nextPc(nextPc), .takeJump(takeJump)
    );

    exceptionFsm #(.handlerVector(handlerVector)) excFsm0 (
        .clk(clk), .rst(rst), .irq(irq), .timerIrq(timerIrq), .cp0Op(cp0Op),
        .stall(stall), .pc4(pc4), .cp0(cp0Bus.fsm), .trapTaken(trapTaken),
        .redirectValid(redirectValid), .redirectPc(redirectPc), .flush(flush)
    );

    cp0Timer #(.timerWidth(timerWidth)) timer0 (
        .clk(clk), .rst(rst), .compareWrite(compareWrite),
        .compareValue(rtValue[timerWidth-1:0]), .count(count), .compare(compare),
        .timerIrq(timerIrq)
    );

    cp0Regs #(.timerWidth(timerWidth)) cp0Regs0 (
        .clk(clk), .rst(rst), .cp0(cp0Bus.regs), .cp0Op(cp0Op),
        .regAddr(instruction[15:11]), .writeData(rtValue), .count(count),
        .compare(compare), .readData(cp0ReadData), .compareWrite(compareWrite)
    );
endmodule

// ==== src/mipsPkg.sv ====
package mipsPkg;

    typedef enum logic [5:0] {
        opRtype = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddi  = 6'h08,
        opSlti  = 6'h0a,
        opAndi  = 6'h0c,
        opOri   = 6'h0d,
        opLui   = 6'h0f,
        opCop0  = 6'h10,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeE;

    typedef enum logic [5:0] {
        fnSll = 6'h00,
        fnSrl = 6'h02,
        fnJr  = 6'h08,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } functE;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluSll, aluSrl, aluLui
    } aluOpE;

    // operand source after forwarding
    typedef enum logic [1:0] {fwdReg, fwdExAlu, fwdMemAlu, fwdMemData} fwdSelE;

    typedef enum logic [1:0] {cpNone, cpMfc0, cpMtc0, cpEret} cp0OpE;

    typedef enum logic [4:0] {
        cpCount   = 5'd9,
        cpCompare = 5'd11,
        cpStatus  = 5'd12,
        cpCause   = 5'd13,
        cpEpc     = 5'd14
    } cp0RegE;

    typedef enum logic [1:0] {excIdle, excTrap, excHandler, excReturn} excStateE;

endpackage

// ==== src/operandSelect.sv ====
module operandSelect import mipsPkg::*; (
    idCtrlIf.operand    ctrl,
    input  logic [31:0] instruction,
    input  logic [31:0] pc4,
    input  logic [31:0] regA,
    input  logic [31:0] regB,
    input  logic [31:0] exAluOut,
    input  logic [31:0] memAluOut,
    input  logic [31:0] memData,
    input  logic [31:0] cp0Data,
    input  logic        stall,
    input  logic        redirectValid,
    input  logic [31:0] redirectPc,
    output logic [31:0] operandA,
    output logic [31:0] operandB,
    output logic [31:0] rtValue,
    output logic [31:0] immediate,
    output logic [31:0] nextPc,
    output logic        takeJump
);
    logic [31:0] rsVal;
    logic [31:0] rtVal;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic        taken;

    function automatic logic [31:0] pick(input fwdSelE sel, input logic [31:0] regVal);
        case (sel)
            fwdExAlu:   return exAluOut;
            fwdMemAlu:  return memAluOut;
            fwdMemData: return memData;
            default:    return regVal;
        endcase
    endfunction

    always_comb begin
        rsVal = pick(ctrl.rsSel, regA);
        rtVal = pick(ctrl.rtSel, regB);
    end

    assign operandA  = ctrl.jal ? pc4 : rsVal;
    assign operandB  = ctrl.jal ? '0 : ctrl.mfc0Sel ? cp0Data : rtVal;
    assign immediate = {ctrl.signExt ? {16{instruction[15]}} : 16'h0000, instruction[15:0]};

    // during a trap this carries the return address into epc
    assign rtValue = redirectValid ? pc4 - 32'd4 : rtVal;

    assign branchTarget = pc4 + {{14{instruction[15]}}, instruction[15:0], 2'b00};
    assign jumpTarget   = {pc4[31:28], instruction[25:0], 2'b00};

    assign taken = ctrl.jump || ctrl.jumpReg || (ctrl.branchEq && rsVal == rtVal) ||
                   (ctrl.branchNe && rsVal != rtVal);

    assign nextPc   = redirectValid ? redirectPc :
                      ctrl.jumpReg ? rsVal :
                      ctrl.jump ? jumpTarget : branchTarget;
    assign takeJump = redirectValid || (taken && !stall);
endmodule

// ==== src/regFile.sv ====
module regFile (
    input  logic        clk,
    input  logic        rst,
    input  logic        writeEnable,
    input  logic [4:0]  writeAddr,
    input  logic [31:0] writeData,
    input  logic [4:0]  readAddrA,
    input  logic [4:0]  readAddrB,
    output logic [31:0] readDataA,
    output logic [31:0] readDataB
);
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != 5'd0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // WB result visible to ID in the same cycle
    assign readDataA = (readAddrA == 5'd0) ? '0 :
                       (writeEnable && writeAddr == readAddrA) ? writeData : regs[readAddrA];
    assign readDataB = (readAddrB == 5'd0) ? '0 :
                       (writeEnable && writeAddr == readAddrB) ? writeData : regs[readAddrB];
endmodule
